/* cpu_pkg.sv */
/* cpu front end shared definitions
   bus and field widths, RV32I opcode classes and memory controller states */
package cpu_pkg;

  // data and instruction words
  typedef logic [31:0] word_t;
  // byte address, the RAM decodes only bits 17:0
  typedef logic [31:0] addr_t;
  // one byte of the memory bus
  typedef logic [7:0] byte_t;

  // RV32I instruction fields
  typedef logic [4:0] reg_addr_t;
  typedef logic [2:0] func3_t;
  typedef logic [6:0] func7_t;
  typedef logic [6:0] opcode_t;

  // byte position within a word
  typedef logic [1:0] byte_idx_t;

  // major opcode classes, illegal stands for anything unrecognised
  typedef enum opcode_t {
    lui     = 7'b0110111,
    auipc   = 7'b0010111,
    jal     = 7'b1101111,
    jalr    = 7'b1100111,
    branch  = 7'b1100011,
    load    = 7'b0000011,
    store   = 7'b0100011,
    op_imm  = 7'b0010011,
    op      = 7'b0110011,
    illegal = 7'b0000000
  } opcode_e;

  typedef enum logic {
    idle,
    read
  } mc_state_e;

  // pc after reset
  localparam addr_t RESET_PC = 32'h0000_0000;
  // bytes per instruction, also the sequential pc step
  localparam int INSTR_BYTES = 4;

endpackage

/* mem_ctrl.sv */
/* memory controller for the instruction path
   reads four bytes one per cycle and assembles a little-endian word */
`timescale 1ns/1ps

module mem_ctrl (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  input  logic            redirect_valid,
  input  logic            fetch_enable,
  input  cpu_pkg::addr_t  fetch_addr,
  output logic            result_enable,
  output cpu_pkg::word_t  result_data,
  output cpu_pkg::addr_t  mem_a,
  input  cpu_pkg::byte_t  mem_din
);
  import cpu_pkg::*;

  mc_state_e state;
  byte_idx_t idx;
  logic      last;
  addr_t     a_reg;
  word_t     shift_buf;

  // a_reg already points one byte ahead during a pause, so show the
  // address whose byte is due on the next ready cycle
  assign mem_a = (!rdy_in && state == read) ? a_reg - 32'd1 : a_reg;

  // last byte comes straight off the bus
  assign result_enable = rdy_in && !redirect_valid && state == read && last;
  assign result_data   = {mem_din, shift_buf[31:8]};

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= idle;
      idx   <= '0;
      last  <= 1'b0;
      a_reg <= RESET_PC;
    end else if (rdy_in) begin
      if (redirect_valid) begin
        state <= idle;
        last  <= 1'b0;
      end else begin
        case (state)
          idle: begin
            if (fetch_enable) begin
              state <= read;
              a_reg <= fetch_addr;
              idx   <= '0;
              last  <= 1'b0;
            end
          end
          read: begin
            if (last) begin
              state <= idle;
              last  <= 1'b0;
            end else begin
              a_reg <= a_reg + 32'd1;
              idx   <= idx + 2'd1;
              if (idx == 2'd3) begin
                last <= 1'b1;
              end
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // first shift holds a stale byte, it drops out after the fourth
  always_ff @(posedge clk_in) begin
    if (rdy_in && state == read) begin
      shift_buf <= {mem_din, shift_buf[31:8]};
    end
  end

endmodule

/* instr_fetcher.sv */
/* instruction fetcher
   walks the pc, requests words from the memory controller, restarts on redirect */
`timescale 1ns/1ps

module instr_fetcher (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  input  logic            redirect_valid,
  input  cpu_pkg::addr_t  redirect_pc,
  output logic            fetch_enable,
  output cpu_pkg::addr_t  fetch_addr,
  input  logic            result_enable,
  input  cpu_pkg::word_t  result_data,
  output logic            decode_enable,
  output cpu_pkg::word_t  instr,
  output cpu_pkg::addr_t  pc
);
  import cpu_pkg::*;

  // one fetch in flight at the controller
  logic pending;

  assign fetch_addr = pc;

  // word goes to the decoder tagged with the pc it was fetched from
  assign decode_enable = result_enable && !redirect_valid;
  assign instr         = result_data;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc           <= RESET_PC;
      pending      <= 1'b0;
      fetch_enable <= 1'b0;
    end else if (rdy_in) begin
      if (redirect_valid) begin
        // old path is dropped, restart at the target
        pc           <= redirect_pc;
        pending      <= 1'b0;
        fetch_enable <= 1'b1;
      end else if (result_enable) begin
        pc           <= pc + INSTR_BYTES;
        pending      <= 1'b0;
        fetch_enable <= 1'b1;
      end else begin
        // first request after reset
        fetch_enable <= !pending && !fetch_enable;
        if (fetch_enable) begin
          pending <= 1'b1;
        end
      end
    end
  end

endmodule

/* decoder.sv */
/* RV32I decoder
   registers the instruction fields and the format-specific immediate */
`timescale 1ns/1ps

module decoder (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                rdy_in,
  input  logic                redirect_valid,
  input  logic                decode_enable,
  input  cpu_pkg::word_t      instr,
  input  cpu_pkg::addr_t      pc,
  output logic                instr_valid,
  output cpu_pkg::addr_t      instr_pc,
  output cpu_pkg::opcode_t    opcode,
  output cpu_pkg::reg_addr_t  rd,
  output cpu_pkg::reg_addr_t  rs1,
  output cpu_pkg::reg_addr_t  rs2,
  output cpu_pkg::func3_t     func3,
  output cpu_pkg::func7_t     func7,
  output cpu_pkg::word_t      imm
);
  import cpu_pkg::*;

  logic    valid_q;
  opcode_e cls;
  word_t   imm_next;

  // held valid shows only on a ready cycle and never in a redirect cycle
  assign instr_valid = valid_q && rdy_in && !redirect_valid;

  always_comb begin
    cls = opcode_e'(instr[6:0]);
    if (!(cls inside {lui, auipc, jal, jalr, branch, load, store, op_imm, op})) begin
      cls = illegal;
    end
    case (cls)
      load, jalr, op_imm: begin
        imm_next = {{20{instr[31]}}, instr[31:20]};
      end
      store: begin
        imm_next = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      branch: begin
        imm_next = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
      end
      lui, auipc: begin
        imm_next = {instr[31:12], 12'b0};
      end
      jal: begin
        imm_next = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};
      end
      // op and illegal carry no immediate
      default: imm_next = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_q <= 1'b0;
    end else if (rdy_in) begin
      valid_q <= decode_enable && !redirect_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && decode_enable) begin
      instr_pc <= pc;
      opcode   <= instr[6:0];
      rd       <= instr[11:7];
      func3    <= instr[14:12];
      rs1      <= instr[19:15];
      rs2      <= instr[24:20];
      func7    <= instr[31:25];
      imm      <= imm_next;
    end
  end

endmodule

/* cpu_front.sv */
/* instruction front end of the RV32I core
   fetcher, byte-serial memory controller and decoder on one memory bus */
`timescale 1ns/1ps

module cpu_front (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                rdy_in,
  input  cpu_pkg::byte_t      mem_din,
  output cpu_pkg::addr_t      mem_a,
  input  logic                redirect_valid,
  input  cpu_pkg::addr_t      redirect_pc,
  output logic                instr_valid,
  output cpu_pkg::addr_t      instr_pc,
  output cpu_pkg::opcode_t    opcode,
  output cpu_pkg::reg_addr_t  rd,
  output cpu_pkg::reg_addr_t  rs1,
  output cpu_pkg::reg_addr_t  rs2,
  output cpu_pkg::func3_t     func3,
  output cpu_pkg::func7_t     func7,
  output cpu_pkg::word_t      imm
);
  import cpu_pkg::*;

  // fetcher and memory controller
  logic  fetch_enable;
  addr_t fetch_addr;
  logic  result_enable;
  word_t result_data;

  // fetcher and decoder
  logic  decode_enable;
  word_t instr;
  addr_t pc;

  mem_ctrl mc_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .redirect_valid (redirect_valid),
    .fetch_enable   (fetch_enable),
    .fetch_addr     (fetch_addr),
    .result_enable  (result_enable),
    .result_data    (result_data),
    .mem_a          (mem_a),
    .mem_din        (mem_din)
  );

  instr_fetcher if_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .fetch_enable   (fetch_enable),
    .fetch_addr     (fetch_addr),
    .result_enable  (result_enable),
    .result_data    (result_data),
    .decode_enable  (decode_enable),
    .instr          (instr),
    .pc             (pc)
  );

  decoder dc_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .redirect_valid (redirect_valid),
    .decode_enable  (decode_enable),
    .instr          (instr),
    .pc             (pc),
    .instr_valid    (instr_valid),
    .instr_pc       (instr_pc),
    .opcode         (opcode),
    .rd             (rd),
    .rs1            (rs1),
    .rs2            (rs2),
    .func3          (func3),
    .func7          (func7),
    .imm            (imm)
  );

endmodule

/* tb_checker.sv */
/* decode stream checker
   compares every instr_valid of the front end with the next expected entry */
`timescale 1ns/1ps

module tb_checker (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               instr_valid,
  input  cpu_pkg::addr_t     instr_pc,
  input  cpu_pkg::opcode_t   opcode,
  input  cpu_pkg::reg_addr_t rd,
  input  cpu_pkg::reg_addr_t rs1,
  input  cpu_pkg::reg_addr_t rs2,
  input  cpu_pkg::func3_t    func3,
  input  cpu_pkg::func7_t    func7,
  input  cpu_pkg::word_t     imm,
  input  int                 entry_total,
  input  cpu_pkg::word_t     exp_pc,
  input  cpu_pkg::word_t     exp_opcode,
  input  cpu_pkg::word_t     exp_rd,
  input  cpu_pkg::word_t     exp_rs1,
  input  cpu_pkg::word_t     exp_rs2,
  input  cpu_pkg::word_t     exp_func3,
  input  cpu_pkg::word_t     exp_func7,
  input  cpu_pkg::word_t     exp_imm,
  output int                 seen_count,
  output int                 fail_count,
  output logic               done
);
  import cpu_pkg::*;

  assign done = (entry_total > 0) && (seen_count >= entry_total);

  // returns 1 and reports the field when it differs
  function automatic int check_field(input int entry, input string field,
                                     input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("mismatch entry %0d %s: expected %08h, actual %08h",
               entry, field, expected, actual);
      return 1;
    end
    return 0;
  endfunction

  always @(posedge clk_in) begin : compare_entry
    int errs;
    errs = 0;
    if (rst_in) begin
      seen_count <= 0;
      fail_count <= 0;
    end else if (instr_valid && seen_count < entry_total) begin
      errs = errs + check_field(seen_count, "pc", exp_pc, instr_pc);
      errs = errs + check_field(seen_count, "opcode", exp_opcode, word_t'(opcode));
      errs = errs + check_field(seen_count, "rd", exp_rd, word_t'(rd));
      errs = errs + check_field(seen_count, "rs1", exp_rs1, word_t'(rs1));
      errs = errs + check_field(seen_count, "rs2", exp_rs2, word_t'(rs2));
      errs = errs + check_field(seen_count, "func3", exp_func3, word_t'(func3));
      errs = errs + check_field(seen_count, "func7", exp_func7, word_t'(func7));
      errs = errs + check_field(seen_count, "imm", exp_imm, imm);
      if (errs == 0) begin
        $display("entry %0d at pc %08h passed", seen_count, exp_pc);
      end else begin
        $display("entry %0d at pc %08h failed in %0d fields", seen_count, exp_pc, errs);
        fail_count <= fail_count + 1;
      end
      seen_count <= seen_count + 1;
    end
  end

endmodule

/* tb_top.sv */
/* front end testbench
   memory model, random rdy_in pauses and one redirect, all driven from the stimulus file */
`timescale 1ns/1ps

module tb_top;
  import cpu_pkg::*;

  localparam int          RESET_CYCLES = 3;
  localparam int          STIM_WORDS   = 256;
  localparam int          MEM_WORDS    = 65536;
  localparam int          MAX_ENTRIES  = 32;
  localparam logic [15:0] LFSR_SEED    = 16'd15609;
  localparam logic [15:0] LFSR_TAPS    = 16'hb400;

  logic      clk_in = 1'b0;
  logic      rst_in;
  logic      rdy_in;
  byte_t     mem_din;
  addr_t     mem_a;
  logic      redirect_valid;
  addr_t     redirect_pc;
  logic      instr_valid;
  addr_t     instr_pc;
  opcode_t   opcode;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  func3_t    func3;
  func7_t    func7;
  word_t     imm;

  word_t stim [STIM_WORDS];
  word_t mem [MEM_WORDS];
  // row layout: pc, opcode, rd, rs1, rs2, func3, func7, imm
  word_t exp_tab [MAX_ENTRIES][8];
  int    entry_total;
  int    redirect_after;
  addr_t redirect_target;
  logic  stim_ok;

  int          cycles;
  int          cycle_limit;
  logic [15:0] lfsr;
  addr_t       prev_a;
  logic        redirect_taken;
  logic        redirect_sent;
  logic        bit_a;
  logic        bit_b;

  int   seen_count;
  int   fail_count;
  logic done;
  int   row;

  always #5 clk_in = ~clk_in;

  cpu_front dut_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .mem_din        (mem_din),
    .mem_a          (mem_a),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .instr_valid    (instr_valid),
    .instr_pc       (instr_pc),
    .opcode         (opcode),
    .rd             (rd),
    .rs1            (rs1),
    .rs2            (rs2),
    .func3          (func3),
    .func7          (func7),
    .imm            (imm)
  );

  assign row = (seen_count < MAX_ENTRIES) ? seen_count : 0;

  tb_checker checker_i (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .instr_valid (instr_valid),
    .instr_pc    (instr_pc),
    .opcode      (opcode),
    .rd          (rd),
    .rs1         (rs1),
    .rs2         (rs2),
    .func3       (func3),
    .func7       (func7),
    .imm         (imm),
    .entry_total (entry_total),
    .exp_pc      (exp_tab[row][0]),
    .exp_opcode  (exp_tab[row][1]),
    .exp_rd      (exp_tab[row][2]),
    .exp_rs1     (exp_tab[row][3]),
    .exp_rs2     (exp_tab[row][4]),
    .exp_func3   (exp_tab[row][5]),
    .exp_func7   (exp_tab[row][6]),
    .exp_imm     (exp_tab[row][7]),
    .seen_count  (seen_count),
    .fail_count  (fail_count),
    .done        (done)
  );

  // galois form, the bit taken is the one shifted out
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ LFSR_TAPS;
    end
    return n;
  endfunction

  function automatic byte_t byte_at(input addr_t a);
    word_t w;
    w = mem[a[17:2]];
    return w[{a[1:0], 3'b000} +: 8];
  endfunction

  task automatic load_stimulus();
    int p;
    int k;
    for (k = 0; k < STIM_WORDS; k++) begin
      stim[k] = '0;
    end
    // words missing from the file carry a pattern of their own address
    for (k = 0; k < MEM_WORDS; k++) begin
      mem[k] = {k[15:0], ~k[15:0]} ^ 32'h5a3c_96e1;
    end
    $readmemh("front_stimulus.txt", stim);
    entry_total = 0;
    redirect_after = -1;
    redirect_target = '0;
    stim_ok = 1'b1;
    p = 0;
    while (p < STIM_WORDS - 9 && stim[p] != '0) begin
      case (stim[p])
        32'd1: begin
          mem[stim[p + 1][17:2]] = stim[p + 2];
          p = p + 3;
        end
        32'd2: begin
          if (entry_total < MAX_ENTRIES) begin
            for (k = 0; k < 8; k++) begin
              exp_tab[entry_total][k] = stim[p + 1 + k];
            end
            entry_total = entry_total + 1;
          end else begin
            $display("stimulus file holds more than %0d expected entries", MAX_ENTRIES);
            stim_ok = 1'b0;
          end
          p = p + 9;
        end
        32'd3: begin
          redirect_after = int'(stim[p + 1]);
          redirect_target = stim[p + 2];
          p = p + 3;
        end
        default: begin
          $display("unknown record kind %0h at word %0d of the stimulus file", stim[p], p);
          stim_ok = 1'b0;
          p = STIM_WORDS;
        end
      endcase
    end
    if (entry_total == 0) begin
      $display("stimulus file holds no expected decode entries");
      stim_ok = 1'b0;
    end
  endtask

  // input driver, everything changes 1 ns after the rising edge
  initial begin
    rst_in = 1'b1;
    rdy_in = 1'b1;
    mem_din = '0;
    redirect_valid = 1'b0;
    redirect_pc = '0;
    redirect_sent = 1'b0;
    lfsr = LFSR_SEED;
    cycles = 0;
    forever begin
      @(posedge clk_in);
      prev_a = mem_a;
      redirect_taken = redirect_valid && rdy_in;
      #1;
      cycles = cycles + 1;
      mem_din = byte_at(prev_a);
      if (cycles >= RESET_CYCLES) begin
        rst_in = 1'b0;
        bit_a = lfsr[0];
        lfsr = lfsr_next(lfsr);
        bit_b = lfsr[0];
        lfsr = lfsr_next(lfsr);
        rdy_in = !(bit_a && bit_b);
        // the pulse is held through paused cycles until a ready edge takes it
        if (redirect_taken) begin
          redirect_valid = 1'b0;
        end else if (!redirect_sent && seen_count == redirect_after) begin
          redirect_valid = 1'b1;
          redirect_pc = redirect_target;
          redirect_sent = 1'b1;
        end
      end
    end
  end

  initial begin
    load_stimulus();
    cycle_limit = entry_total * 40 + 200;
    if (stim_ok) begin
      while (!done && cycles < cycle_limit) begin
        @(posedge clk_in);
      end
    end
    #2;
    if (stim_ok && !done) begin
      $display("timeout after %0d cycles with %0d of %0d entries seen",
               cycles, seen_count, entry_total);
    end
    $display("entries %0d, seen %0d, passed %0d, failed %0d",
             entry_total, seen_count, seen_count - fail_count, fail_count);
    if (stim_ok && done && fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* front_stimulus.txt */
// kind 1 memory word: 1 <byte address> <word>; kind 3 redirect: 3 <entries seen> <target>
// kind 2 expected decode: 2 <pc> <opcode> <rd> <rs1> <rs2> <func3> <func7> <imm>
1 00000000 123452b7
1 00000004 fffff517
1 00000008 ff9ff0ef
1 0000000c 00c08067
1 00000010 fe3118e3
1 00000014 ffc42303
1 00000040 0074aa23
1 00000044 fff60593
1 00000048 40f706b3
1 0000004c 12345678
2 00000000 37 05 08 03 5 09 12345000
2 00000004 17 0a 1f 1f 7 7f fffff000
2 00000008 6f 01 1f 19 7 7f fffffff8
2 0000000c 67 00 01 0c 0 00 0000000c
2 00000010 63 11 02 03 1 7f fffffff0
2 00000014 03 06 08 1c 2 7f fffffffc
3 00000006 00000040
2 00000040 23 14 09 07 2 00 00000014
2 00000044 13 0b 0c 1f 0 7f ffffffff
2 00000048 33 0d 0e 0f 0 20 00000000
2 0000004c 78 0c 08 03 5 09 00000000

/* tb.f */
cpu_pkg.sv
mem_ctrl.sv
instr_fetcher.sv
decoder.sv
cpu_front.sv
tb_checker.sv
tb_top.sv

/* run.sh */
#!/bin/sh
# build the front end testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_top -f tb.f > build.log 2>&1
then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_top > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -q "TEST PASSED" sim.log; then
  exit 0
fi
exit 1
